// File: rtl/zynq_shell_pkg.sv
package zynq_shell_pkg;

   // the GP1 port drops the top two bits of the PS physical address
   localparam int PS_ADDR_W  = 30;
   // processor physical addresses and DRAM addresses share one width
   localparam int BP_ADDR_W  = 32;
   localparam int CSR_DATA_W = 32;
   localparam int CSR_IDX_W  = 5;

   typedef logic [PS_ADDR_W-1:0]  ps_addr_t;
   typedef logic [BP_ADDR_W-1:0]  bp_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_word_t;
   typedef logic [CSR_IDX_W-1:0]  csr_idx_t;

   // one free-running counter per stall event
   localparam int NUM_EVENTS = 8;
   localparam int COUNTER_W  = 64;

   typedef logic [COUNTER_W-1:0]  counter_t;
   typedef logic [NUM_EVENTS-1:0] event_vec_t;

   // each bitmap bit covers an 8 MiB slice of the 1 GiB below bit 30
   localparam int PROFILE_REGIONS = 128;
   localparam int PROFILE_IDX_W   = $clog2(PROFILE_REGIONS);
   localparam int PROFILE_LSB     = 23;
   // the bitmap is read back as this many register words
   localparam int PROFILE_WORDS   = PROFILE_REGIONS / CSR_DATA_W;

   typedef logic [PROFILE_REGIONS-1:0] profile_vec_t;

   // processor DRAM starts here, the PS side is zero based before rebasing
   localparam bp_addr_t DRAM_BP_BASE = 32'h8000_0000;
   // size of the DRAM block that the PS hands out to the shell
   localparam bp_addr_t DRAM_LIMIT   = 32'(241 * 1024 * 1024);

   // write side register map
   localparam csr_idx_t CSR_WR_RUN       = 5'd0;
   localparam csr_idx_t CSR_WR_DRAM_BASE = 5'd1;

   // read side register map, the bitmap words come lowest word first
   localparam csr_idx_t CSR_RD_PROFILE0  = 5'd0;
   localparam csr_idx_t CSR_RD_STATUS    = 5'd4;
   // counter k has its low half at 5+2k and its high half at 6+2k
   localparam csr_idx_t CSR_RD_COUNTER0  = 5'd5;

endpackage

// File: rtl/shell_csr.sv
module shell_csr
   import zynq_shell_pkg::*;
   (
    input  logic                         aclk_i
   ,input  logic                         rst_n_i

   ,input  logic                         csr_wr_v_i
   ,input  csr_idx_t                     csr_wr_idx_i
   ,input  csr_word_t                    csr_wr_data_i

   ,input  logic                         csr_rd_v_i
   ,input  csr_idx_t                     csr_rd_idx_i
   ,output logic                         csr_rd_v_o
   ,output csr_word_t                    csr_rd_data_o

   ,input  profile_vec_t                 profile_i
   ,input  logic                         over_limit_i
   ,input  counter_t [NUM_EVENTS-1:0]    counters_i

   ,output logic                         core_reset_o
   ,output bp_addr_t                     dram_base_o
   );

   logic      run_r;
   bp_addr_t  dram_base_r;
   csr_word_t rd_word;
   csr_idx_t  prof_off;
   csr_idx_t  cnt_off;

   // control registers, the PS may write them at any cycle
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         run_r       <= 1'b0;
         dram_base_r <= '0;
      end
      else if (csr_wr_v_i)
      begin
         // only bit 0 of the run word is meaningful
         if (csr_wr_idx_i == CSR_WR_RUN)
            run_r <= csr_wr_data_i[0];
         if (csr_wr_idx_i == CSR_WR_DRAM_BASE)
            dram_base_r <= csr_wr_data_i;
      end
   end

   // the core stays in reset until software sets the run bit
   assign core_reset_o = ~run_r;
   assign dram_base_o  = dram_base_r;

   // offsets of the read index within the bitmap and counter windows
   assign prof_off = csr_rd_idx_i - CSR_RD_PROFILE0;
   assign cnt_off  = csr_rd_idx_i - CSR_RD_COUNTER0;

   // status read multiplexer, unmapped indices return zero
   always_comb
   begin
      rd_word = '0;
      if (csr_rd_idx_i < CSR_RD_PROFILE0 + PROFILE_WORDS)
         rd_word = profile_i[prof_off * CSR_DATA_W +: CSR_DATA_W];
      else if (csr_rd_idx_i == CSR_RD_STATUS)
         rd_word = {{(CSR_DATA_W-1){1'b0}}, over_limit_i};
      else if ((csr_rd_idx_i >= CSR_RD_COUNTER0)
               && (csr_rd_idx_i < CSR_RD_COUNTER0 + 2 * NUM_EVENTS))
         // the odd offset picks the upper half of the counter
         rd_word = counters_i[cnt_off >> 1][cnt_off[0] * CSR_DATA_W +: CSR_DATA_W];
   end

   // the answer leaves one cycle after the strobe and shows the state at that edge
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         csr_rd_v_o    <= 1'b0;
         csr_rd_data_o <= '0;
      end
      else
      begin
         csr_rd_v_o <= csr_rd_v_i;
         if (csr_rd_v_i)
            csr_rd_data_o <= rd_word;
      end
   end

endmodule

// File: rtl/addr_map.sv
module addr_map
   import zynq_shell_pkg::*;
   (
    input  logic     aclk_i
   ,input  logic     rst_n_i

   // inbound requests from the PS window
   ,input  logic     ps_req_v_i
   ,input  ps_addr_t ps_req_addr_i
   ,output logic     bp_req_v_o
   ,output bp_addr_t bp_req_addr_o

   // outbound DRAM requests from the core side
   ,input  logic     dram_req_v_i
   ,input  logic     dram_req_we_i
   ,input  bp_addr_t dram_req_addr_i
   ,input  bp_addr_t dram_base_i
   ,output logic     axi_req_v_o
   ,output logic     axi_req_we_o
   ,output bp_addr_t axi_req_addr_o
   );

   bp_addr_t bp_addr_translated;
   bp_addr_t axi_addr_rebased;

   // window translation of the GP1 port
   // port 0x0000_0000 to 0x0FFF_FFFF lands on processor 0x8000_0000 and up
   // port 0x2000_0000 to 0x2FFF_FFFF lands on processor 0x0000_0000 and up
   assign bp_addr_translated = {~ps_req_addr_i[29], 3'b000, ps_req_addr_i[27:0]};

   // strip the processor DRAM base and move into the block the PS allocated
   // the sum wraps at 32 bits
   assign axi_addr_rebased = (dram_req_addr_i ^ DRAM_BP_BASE) + dram_base_i;

   // inbound stage, one request in flight, a new one may follow every cycle
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         bp_req_v_o    <= 1'b0;
         bp_req_addr_o <= '0;
      end
      else
      begin
         bp_req_v_o <= ps_req_v_i;
         // the address only moves with a valid request
         if (ps_req_v_i)
            bp_req_addr_o <= bp_addr_translated;
      end
   end

   // outbound stage, the base is the one held at the request edge
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         axi_req_v_o    <= 1'b0;
         axi_req_we_o   <= 1'b0;
         axi_req_addr_o <= '0;
      end
      else
      begin
         axi_req_v_o <= dram_req_v_i;
         if (dram_req_v_i)
         begin
            axi_req_we_o   <= dram_req_we_i;
            axi_req_addr_o <= axi_addr_rebased;
         end
      end
   end

endmodule

// File: rtl/dram_profiler.sv
module dram_profiler
   import zynq_shell_pkg::*;
   (
    input  logic         aclk_i
   ,input  logic         rst_n_i

   ,input  logic         core_reset_i

   ,input  logic         dram_req_v_i
   ,input  bp_addr_t     dram_req_addr_i

   ,output profile_vec_t profile_o
   ,output logic         over_limit_o
   );

   profile_vec_t                   profile_r;
   logic                           over_limit_r;
   logic [PROFILE_IDX_W-1:0]       region_idx;
   logic                           beyond_limit;

   // region index comes from the raw processor address, bits 29 down to 23
   assign region_idx = dram_req_addr_i[PROFILE_LSB +: PROFILE_IDX_W];

   // offset into processor DRAM compared against the allocated size
   assign beyond_limit = (dram_req_addr_i ^ DRAM_BP_BASE) >= DRAM_LIMIT;

   // both records are sticky until the core is put back into reset
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         profile_r    <= '0;
         over_limit_r <= 1'b0;
      end
      else if (core_reset_i)
      begin
         // a fresh run starts with a clean map
         profile_r    <= '0;
         over_limit_r <= 1'b0;
      end
      else if (dram_req_v_i)
      begin
         profile_r[region_idx] <= 1'b1;
         if (beyond_limit)
            over_limit_r <= 1'b1;
      end
   end

   assign profile_o    = profile_r;
   assign over_limit_o = over_limit_r;

endmodule

// File: rtl/stall_counters.sv
module stall_counters
   import zynq_shell_pkg::*;
   (
    input  logic                      aclk_i
   ,input  logic                      rst_n_i

   // the counters follow the life of the core
   ,input  logic                      core_reset_i
   // nothing counts while the core is frozen
   ,input  logic                      freeze_i

   ,input  event_vec_t                event_i

   ,output counter_t [NUM_EVENTS-1:0] counters_o
   );

   counter_t [NUM_EVENTS-1:0] count_r;
   logic                      count_en;

   // core reset has priority in the register below, so freeze alone gates counting
   assign count_en = ~freeze_i;

   // one counter per event line, all counters share the same enable rules
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         count_r <= '0;
      end
      else if (core_reset_i)
      begin
         // cleared synchronously on every core reset cycle
         count_r <= '0;
      end
      else
      begin
         for (int k = 0; k < NUM_EVENTS; k++)
         begin
            // 64 bits never wrap in practice, the sum still wraps cleanly
            if (count_en && event_i[k])
               count_r[k] <= count_r[k] + counter_t'(1);
         end
      end
   end

   assign counters_o = count_r;

endmodule

// File: rtl/zynq_bp_shell.sv
module zynq_bp_shell
   import zynq_shell_pkg::*;
   (
    input  logic       aclk_i
   ,input  logic       rst_n_i

   // register bus from the PS
   ,input  logic       csr_wr_v_i
   ,input  csr_idx_t   csr_wr_idx_i
   ,input  csr_word_t  csr_wr_data_i
   ,input  logic       csr_rd_v_i
   ,input  csr_idx_t   csr_rd_idx_i
   ,output logic       csr_rd_v_o
   ,output csr_word_t  csr_rd_data_o

   // PS reads and writes into the processor address space
   ,input  logic       ps_req_v_i
   ,input  ps_addr_t   ps_req_addr_i
   ,output logic       bp_req_v_o
   ,output bp_addr_t   bp_req_addr_o

   // processor DRAM requests towards the PS memory port
   ,input  logic       dram_req_v_i
   ,input  logic       dram_req_we_i
   ,input  bp_addr_t   dram_req_addr_i
   ,output logic       axi_req_v_o
   ,output logic       axi_req_we_o
   ,output bp_addr_t   axi_req_addr_o

   // stall events sampled from the core
   ,input  event_vec_t event_i
   ,input  logic       freeze_i

   ,output logic       core_reset_o
   );

   bp_addr_t                  dram_base_lo;
   profile_vec_t              profile_lo;
   logic                      over_limit_lo;
   counter_t [NUM_EVENTS-1:0] counters_lo;

   // register bank, owns the run bit that drives the core reset
   shell_csr u_csr
      (.aclk_i       (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.csr_wr_v_i   (csr_wr_v_i)
      ,.csr_wr_idx_i (csr_wr_idx_i)
      ,.csr_wr_data_i(csr_wr_data_i)
      ,.csr_rd_v_i   (csr_rd_v_i)
      ,.csr_rd_idx_i (csr_rd_idx_i)
      ,.csr_rd_v_o   (csr_rd_v_o)
      ,.csr_rd_data_o(csr_rd_data_o)
      ,.profile_i    (profile_lo)
      ,.over_limit_i (over_limit_lo)
      ,.counters_i   (counters_lo)
      ,.core_reset_o (core_reset_o)
      ,.dram_base_o  (dram_base_lo)
      );

   // inbound translation and outbound rebasing
   addr_map u_addr_map
      (.aclk_i         (aclk_i)
      ,.rst_n_i        (rst_n_i)
      ,.ps_req_v_i     (ps_req_v_i)
      ,.ps_req_addr_i  (ps_req_addr_i)
      ,.bp_req_v_o     (bp_req_v_o)
      ,.bp_req_addr_o  (bp_req_addr_o)
      ,.dram_req_v_i   (dram_req_v_i)
      ,.dram_req_we_i  (dram_req_we_i)
      ,.dram_req_addr_i(dram_req_addr_i)
      ,.dram_base_i    (dram_base_lo)
      ,.axi_req_v_o    (axi_req_v_o)
      ,.axi_req_we_o   (axi_req_we_o)
      ,.axi_req_addr_o (axi_req_addr_o)
      );

   // watches the raw processor addresses, before rebasing
   dram_profiler u_profiler
      (.aclk_i         (aclk_i)
      ,.rst_n_i        (rst_n_i)
      ,.core_reset_i   (core_reset_o)
      ,.dram_req_v_i   (dram_req_v_i)
      ,.dram_req_addr_i(dram_req_addr_i)
      ,.profile_o      (profile_lo)
      ,.over_limit_o   (over_limit_lo)
      );

   stall_counters u_counters
      (.aclk_i      (aclk_i)
      ,.rst_n_i     (rst_n_i)
      ,.core_reset_i(core_reset_o)
      ,.freeze_i    (freeze_i)
      ,.event_i     (event_i)
      ,.counters_o  (counters_lo)
      );

endmodule

// File: verif/clk_gen.sv
module clk_gen
   (
    output logic clk_o
   ,output logic rst_n_o
   );

   // free running clock with a period of 10
   initial
   begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // reset is held for three rising edges and released on a falling edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (3) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// File: verif/zynq_bp_shell_props.sv
module zynq_bp_shell_props
   import zynq_shell_pkg::*;
   (
    input  logic     aclk_i
   ,input  logic     rst_n_i

   // register write port, only the run bit matters here
   ,input  logic     wr_v_i
   ,input  csr_idx_t wr_idx_i
   ,input  logic     wr_bit0_i

   // strobes in and the valids that answer them
   ,input  logic     rd_strobe_i
   ,input  logic     rd_valid_i
   ,input  logic     ps_v_i
   ,input  logic     bp_v_i
   ,input  logic     dram_v_i
   ,input  logic     axi_v_i

   ,input  logic     core_reset_i
   );

   logic run_set_seen;

   // remembers whether the run bit was ever written with a one
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         run_set_seen <= 1'b0;
      else if (wr_v_i && (wr_idx_i == CSR_WR_RUN) && wr_bit0_i)
         run_set_seen <= 1'b1;
   end

   // each valid output is its input strobe delayed by one edge
   bp_follows_ps: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      bp_v_i == $past(ps_v_i))
      else $error("bp_req_v_o did not follow ps_req_v_i by one cycle");

   axi_follows_dram: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      axi_v_i == $past(dram_v_i))
      else $error("axi_req_v_o did not follow dram_req_v_i by one cycle");

   rd_follows_strobe: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rd_valid_i == $past(rd_strobe_i))
      else $error("csr_rd_v_o did not follow csr_rd_v_i by one cycle");

   // the core has no way out of reset before software sets the run bit
   reset_until_run: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      !run_set_seen |-> core_reset_i)
      else $error("core_reset_o dropped before the run bit was set");

endmodule

// File: verif/tb_zynq_bp_shell.sv
module tb_zynq_bp_shell
   import zynq_shell_pkg::*;
   ();

   localparam int unsigned RAND_SEED = 32'hf8dd8c4c;
   localparam int N_INBOUND  = 200;
   localparam int N_BASES    = 4;
   localparam int N_PER_BASE = 30;
   localparam int N_COUNT    = 300;
   localparam int N_PROF_LOW = 40;
   localparam int N_PROF_MIX = 60;
   // inbound gaps can double that phase, register traffic is counted with room to spare
   localparam int STIM_CYCLES = 64 + 2 * N_INBOUND + N_BASES * (N_PER_BASE + 1)
                              + N_COUNT + 6 * NUM_EVENTS + N_PROF_LOW + N_PROF_MIX + 32;
   localparam int MARGIN = 200;
   localparam int WATCHDOG_TIME = (STIM_CYCLES + MARGIN) * 10;

   logic       aclk;
   logic       rst_n;
   logic       csr_wr_v;
   csr_idx_t   csr_wr_idx;
   csr_word_t  csr_wr_data;
   logic       csr_rd_v;
   csr_idx_t   csr_rd_idx;
   logic       csr_rd_v_o;
   csr_word_t  csr_rd_data_o;
   logic       ps_req_v;
   ps_addr_t   ps_req_addr;
   logic       bp_req_v_o;
   bp_addr_t   bp_req_addr_o;
   logic       dram_req_v;
   logic       dram_req_we;
   bp_addr_t   dram_req_addr;
   logic       axi_req_v_o;
   logic       axi_req_we_o;
   bp_addr_t   axi_req_addr_o;
   event_vec_t event_in;
   logic       freeze;
   logic       core_reset_o;

   // reference model of the shell state
   logic         m_run;
   bp_addr_t     m_base;
   profile_vec_t m_profile;
   logic         m_over;
   counter_t     m_cnt [NUM_EVENTS];

   clk_gen u_clk_gen
      (.clk_o  (aclk)
      ,.rst_n_o(rst_n)
      );

   zynq_bp_shell UUT
      (.aclk_i         (aclk)
      ,.rst_n_i        (rst_n)
      ,.csr_wr_v_i     (csr_wr_v)
      ,.csr_wr_idx_i   (csr_wr_idx)
      ,.csr_wr_data_i  (csr_wr_data)
      ,.csr_rd_v_i     (csr_rd_v)
      ,.csr_rd_idx_i   (csr_rd_idx)
      ,.csr_rd_v_o     (csr_rd_v_o)
      ,.csr_rd_data_o  (csr_rd_data_o)
      ,.ps_req_v_i     (ps_req_v)
      ,.ps_req_addr_i  (ps_req_addr)
      ,.bp_req_v_o     (bp_req_v_o)
      ,.bp_req_addr_o  (bp_req_addr_o)
      ,.dram_req_v_i   (dram_req_v)
      ,.dram_req_we_i  (dram_req_we)
      ,.dram_req_addr_i(dram_req_addr)
      ,.axi_req_v_o    (axi_req_v_o)
      ,.axi_req_we_o   (axi_req_we_o)
      ,.axi_req_addr_o (axi_req_addr_o)
      ,.event_i        (event_in)
      ,.freeze_i       (freeze)
      ,.core_reset_o   (core_reset_o)
      );

   bind zynq_bp_shell zynq_bp_shell_props u_props
      (.aclk_i      (aclk_i)
      ,.rst_n_i     (rst_n_i)
      ,.wr_v_i      (csr_wr_v_i)
      ,.wr_idx_i    (csr_wr_idx_i)
      ,.wr_bit0_i   (csr_wr_data_i[0])
      ,.rd_strobe_i (csr_rd_v_i)
      ,.rd_valid_i  (csr_rd_v_o)
      ,.ps_v_i      (ps_req_v_i)
      ,.bp_v_i      (bp_req_v_o)
      ,.dram_v_i    (dram_req_v_i)
      ,.axi_v_i     (axi_req_v_o)
      ,.core_reset_i(core_reset_o)
      );

   task automatic check_word(input csr_word_t act, input csr_word_t exp, input string name);
      if (act !== exp)
      begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, name, act, exp);
         $display("tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_addr(input bp_addr_t act, input bp_addr_t exp, input string name);
      if (act !== exp)
      begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, name, act, exp);
         $display("tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_bit(input logic act, input logic exp, input string name);
      if (act !== exp)
      begin
         $display("[ERROR] %0t: %s is %b, expected %b", $time, name, act, exp);
         $display("tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // window rule: bits 27 to 0 pass through, bit 31 is set for the lower half of the port
   function automatic bp_addr_t translate(input ps_addr_t a);
      bp_addr_t t;
      t = '0;
      t[27:0] = a[27:0];
      t[31] = (a[29] == 1'b0);
      return t;
   endfunction

   // what a read at this index should return, from the model as it stands now
   function automatic csr_word_t model_read(input csr_idx_t idx);
      int i;
      int k;
      csr_word_t word;
      i = idx;
      word = '0;
      if (i < CSR_RD_STATUS)
         word = m_profile[32 * i +: 32];
      else if (i == CSR_RD_STATUS)
         word = {31'b0, m_over};
      else if (i < CSR_RD_COUNTER0 + 2 * NUM_EVENTS)
      begin
         k = (i - CSR_RD_COUNTER0) / 2;
         word = ((i - CSR_RD_COUNTER0) % 2 == 0) ? m_cnt[k][31:0] : m_cnt[k][63:32];
      end
      return word;
   endfunction

   // applies the coming rising edge to the model, then waits for the next falling edge
   task automatic advance();
      if (!m_run)
      begin
         // core reset clears all run statistics
         m_profile = '0;
         m_over    = 1'b0;
         for (int k = 0; k < NUM_EVENTS; k++)
            m_cnt[k] = '0;
      end
      else
      begin
         for (int k = 0; k < NUM_EVENTS; k++)
            if (!freeze && event_in[k])
               m_cnt[k] = m_cnt[k] + 1;
         if (dram_req_v)
         begin
            m_profile[dram_req_addr[29:23]] = 1'b1;
            if ((dram_req_addr ^ DRAM_BP_BASE) >= DRAM_LIMIT)
               m_over = 1'b1;
         end
      end
      // register writes land at the same edge, after the old run bit was used
      if (csr_wr_v && (csr_wr_idx == CSR_WR_RUN))
         m_run = csr_wr_data[0];
      if (csr_wr_v && (csr_wr_idx == CSR_WR_DRAM_BASE))
         m_base = csr_wr_data;
      @(negedge aclk);
   endtask

   task automatic csr_write(input csr_idx_t idx, input csr_word_t data);
      csr_wr_v    = 1'b1;
      csr_wr_idx  = idx;
      csr_wr_data = data;
      advance();
      csr_wr_v    = 1'b0;
   endtask

   // the answer comes exactly one edge after the strobe
   task automatic read_expect(input csr_idx_t idx, input csr_word_t exp);
      csr_rd_v   = 1'b1;
      csr_rd_idx = idx;
      advance();
      csr_rd_v   = 1'b0;
      check_bit(csr_rd_v_o, 1'b1, "csr_rd_v_o");
      check_word(csr_rd_data_o, exp, $sformatf("csr read index %0d", idx));
   endtask

   task automatic ps_request(input ps_addr_t addr);
      bp_addr_t exp;
      exp = translate(addr);
      ps_req_v    = 1'b1;
      ps_req_addr = addr;
      advance();
      ps_req_v    = 1'b0;
      check_bit(bp_req_v_o, 1'b1, "bp_req_v_o");
      check_addr(bp_req_addr_o, exp, "bp_req_addr_o");
   endtask

   // the base in effect is the one the model holds before this edge
   task automatic dram_request(input bp_addr_t addr, input logic we);
      bp_addr_t exp;
      exp = (addr ^ DRAM_BP_BASE) + m_base;
      dram_req_v    = 1'b1;
      dram_req_we   = we;
      dram_req_addr = addr;
      advance();
      dram_req_v    = 1'b0;
      check_bit(axi_req_v_o, 1'b1, "axi_req_v_o");
      check_bit(axi_req_we_o, we, "axi_req_we_o");
      check_addr(axi_req_addr_o, exp, "axi_req_addr_o");
   endtask

   // ends a run that stops making progress
   initial
   begin
      #(WATCHDOG_TIME);
      $display("watchdog expired after %0d time units, the run hung", WATCHDOG_TIME);
      $display("tests failed");
      $fatal(1, "timeout");
   end

   initial
   begin : stimulus
      bp_addr_t    addr;
      void'($urandom(RAND_SEED));
      csr_wr_v      = 1'b0;
      csr_wr_idx    = '0;
      csr_wr_data   = '0;
      csr_rd_v      = 1'b0;
      csr_rd_idx    = '0;
      ps_req_v      = 1'b0;
      ps_req_addr   = '0;
      dram_req_v    = 1'b0;
      dram_req_we   = 1'b0;
      dram_req_addr = '0;
      event_in      = '0;
      freeze        = 1'b0;
      m_run         = 1'b0;
      m_base        = '0;
      m_profile     = '0;
      m_over        = 1'b0;
      for (int k = 0; k < NUM_EVENTS; k++)
         m_cnt[k] = '0;
      wait (rst_n === 1'b1);
      @(negedge aclk);

      // state right after reset, every index must read zero
      check_bit(core_reset_o, 1'b1, "core_reset_o");
      check_bit(bp_req_v_o, 1'b0, "bp_req_v_o");
      check_bit(axi_req_v_o, 1'b0, "axi_req_v_o");
      check_bit(csr_rd_v_o, 1'b0, "csr_rd_v_o");
      for (int i = 0; i < 32; i++)
         read_expect(csr_idx_t'(i), '0);

      // inbound window, an idle cycle now and then, otherwise back to back
      for (int i = 0; i < N_INBOUND; i++)
      begin
         if ($urandom_range(3) == 0)
         begin
            advance();
            check_bit(bp_req_v_o, 1'b0, "bp_req_v_o");
         end
         ps_request(ps_addr_t'($urandom));
      end

      // outbound rebasing under several bases
      for (int b = 0; b < N_BASES; b++)
      begin
         csr_write(CSR_WR_DRAM_BASE, $urandom);
         for (int j = 0; j < N_PER_BASE; j++)
            dram_request($urandom, $urandom_range(1));
      end

      // stall counters with random events and freeze
      csr_write(CSR_WR_RUN, 32'd1);
      for (int c = 0; c < N_COUNT; c++)
      begin
         event_in = event_vec_t'($urandom);
         freeze   = ($urandom_range(3) == 0);
         advance();
      end
      event_in = '0;
      freeze   = 1'b0;
      for (int i = CSR_RD_COUNTER0; i < CSR_RD_COUNTER0 + 2 * NUM_EVENTS; i++)
         read_expect(csr_idx_t'(i), model_read(csr_idx_t'(i)));
      // one core reset cycle clears them all
      csr_write(CSR_WR_RUN, 32'd0);
      check_bit(core_reset_o, 1'b1, "core_reset_o");
      csr_write(CSR_WR_RUN, 32'd1);
      check_bit(core_reset_o, 1'b0, "core_reset_o");
      for (int i = CSR_RD_COUNTER0; i < CSR_RD_COUNTER0 + 2 * NUM_EVENTS; i++)
         read_expect(csr_idx_t'(i), '0);

      // profiler, first inside the allocated block only
      for (int i = 0; i < N_PROF_LOW; i++)
         dram_request(DRAM_BP_BASE | ($urandom % DRAM_LIMIT), $urandom_range(1));
      for (int i = 0; i <= CSR_RD_STATUS; i++)
         read_expect(csr_idx_t'(i), model_read(csr_idx_t'(i)));
      // then a mix of near and far addresses, many of them over the limit
      for (int i = 0; i < N_PROF_MIX; i++)
      begin
         if ($urandom_range(1) == 1)
            addr = DRAM_BP_BASE | ($urandom % (2 * DRAM_LIMIT));
         else
            addr = $urandom;
         dram_request(addr, $urandom_range(1));
      end
      for (int i = 0; i <= CSR_RD_STATUS; i++)
         read_expect(csr_idx_t'(i), model_read(csr_idx_t'(i)));
      csr_write(CSR_WR_RUN, 32'd0);
      csr_write(CSR_WR_RUN, 32'd1);
      for (int i = 0; i <= CSR_RD_STATUS; i++)
         read_expect(csr_idx_t'(i), '0);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: all.f
rtl/zynq_shell_pkg.sv
rtl/shell_csr.sv
rtl/addr_map.sv
rtl/dram_profiler.sv
rtl/stall_counters.sv
rtl/zynq_bp_shell.sv
verif/clk_gen.sv
verif/zynq_bp_shell_props.sv
verif/tb_zynq_bp_shell.sv

// File: Bender.yml
package:
  name: zynq_bp_shell

sources:
  # design, package first
  - rtl/zynq_shell_pkg.sv
  - rtl/shell_csr.sv
  - rtl/addr_map.sv
  - rtl/dram_profiler.sv
  - rtl/stall_counters.sv
  - rtl/zynq_bp_shell.sv
  # testbench
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/zynq_bp_shell_props.sv
      - verif/tb_zynq_bp_shell.sv
